// File: design/activeList.sv
// **************************************************
// Active list top level
// Controller plus payload store, completion table
// and fault tracker
// **************************************************

`default_nettype none

`include "activeList_consts.svh"

module activeList (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dispatchValid [`AL_DISPATCH_WIDTH],
    input  activeListPkg::pcAddr     dispatchPc [`AL_DISPATCH_WIDTH],
    input  activeListPkg::archReg    dispatchDest [`AL_DISPATCH_WIDTH],
    output activeListPkg::alIndex    dispatchTag [`AL_DISPATCH_WIDTH],
    input  logic                     wbValid [`AL_WB_WIDTH],
    input  activeListPkg::alIndex    wbTag [`AL_WB_WIDTH],
    input  logic                     wbFault [`AL_WB_WIDTH],
    input  activeListPkg::faultCause wbCause [`AL_WB_WIDTH],
    output logic                     commitValid [`AL_COMMIT_WIDTH],
    output activeListPkg::pcAddr     commitPc [`AL_COMMIT_WIDTH],
    output activeListPkg::archReg    commitDest [`AL_COMMIT_WIDTH],
    output logic                     flushValid [`AL_COMMIT_WIDTH],
    output activeListPkg::pcAddr     flushPc [`AL_COMMIT_WIDTH],
    output activeListPkg::archReg    flushDest [`AL_COMMIT_WIDTH],
    output logic                     faultValid,
    output activeListPkg::pcAddr     faultPc,
    output activeListPkg::faultCause faultCause,
    output activeListPkg::alCount    creditReturn,
    output logic                     recovering
);

    activeListPkg::alIndex head;
    activeListPkg::alIndex tail;
    activeListPkg::alIndex readTag [`AL_COMMIT_WIDTH];
    activeListPkg::alIndex pushTag [`AL_DISPATCH_WIDTH];
    logic headDone [`AL_COMMIT_WIDTH];
    logic faultPending;
    activeListPkg::alIndex faultTag;
    logic clearFault;
    activeListPkg::pcAddr readPc [`AL_COMMIT_WIDTH];
    activeListPkg::archReg readDest [`AL_COMMIT_WIDTH];
    activeListPkg::pcAddr wbPc [`AL_WB_WIDTH];

    activeListControl control (
        .clk(clk), .reset(reset), .dispatchValid(dispatchValid),
        .headDone(headDone), .faultPending(faultPending), .faultTag(faultTag),
        .head(head), .tail(tail), .readTag(readTag), .pushTag(pushTag),
        .commitValid(commitValid), .flushValid(flushValid),
        .faultValid(faultValid), .clearFault(clearFault),
        .creditReturn(creditReturn), .recovering(recovering)
    );

    entryStore payloadStore (
        .clk(clk), .pushValid(dispatchValid), .pushTag(pushTag),
        .pushPc(dispatchPc), .pushDest(dispatchDest),
        .readTag(readTag), .readPc(readPc), .readDest(readDest),
        .wbReadTag(wbTag), .wbPc(wbPc)
    );

    completionTable doneTable (
        .clk(clk), .reset(reset), .pushValid(dispatchValid), .pushTag(pushTag),
        .wbValid(wbValid), .wbTag(wbTag), .readTag(readTag), .headDone(headDone)
    );

    faultTracker faultRecord (
        .clk(clk), .reset(reset), .head(head),
        .wbValid(wbValid), .wbTag(wbTag), .wbFault(wbFault), .wbCause(wbCause),
        .wbPc(wbPc), .clearFault(clearFault),
        .faultPending(faultPending), .faultTag(faultTag),
        .faultCause(faultCause), .faultPc(faultPc)
    );

    // Lane i lands i slots past the tail
    always_comb begin
        for (int i = 0; i < `AL_DISPATCH_WIDTH; i++) begin
            dispatchTag[i] = tail + activeListPkg::alIndex'(i);
        end
    end

    // Same read ports feed commit and flush, the valids tell which
    always_comb begin
        for (int i = 0; i < `AL_COMMIT_WIDTH; i++) begin
            commitPc[i] = readPc[i];
            commitDest[i] = readDest[i];
            flushPc[i] = readPc[i];
            flushDest[i] = readDest[i];
        end
    end

endmodule

`default_nettype wire

// File: design/activeListControl.sv
// **************************************************
// Active list controller
// Head, tail and count pointers, commit/flush lanes,
// credit return and the recovery state machine
// **************************************************

`default_nettype none

`include "activeList_consts.svh"

module activeListControl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dispatchValid [`AL_DISPATCH_WIDTH],
    input  logic                   headDone [`AL_COMMIT_WIDTH],
    input  logic                   faultPending,
    input  activeListPkg::alIndex  faultTag,
    output activeListPkg::alIndex  head,
    output activeListPkg::alIndex  tail,
    output activeListPkg::alIndex  readTag [`AL_COMMIT_WIDTH],
    output activeListPkg::alIndex  pushTag [`AL_DISPATCH_WIDTH],
    output logic                   commitValid [`AL_COMMIT_WIDTH],
    output logic                   flushValid [`AL_COMMIT_WIDTH],
    output logic                   faultValid,
    output logic                   clearFault,
    output activeListPkg::alCount  creditReturn,
    output logic                   recovering
);

    activeListPkg::recoveryState state;
    activeListPkg::recoveryState stateNext;
    activeListPkg::alCount count;
    activeListPkg::laneCount pushNum;
    activeListPkg::laneCount popNum;
    logic faultAtHead;
    logic commitChain;

    // Tail slots for the pushed lanes, packed in lane order
    always_comb begin
        pushNum = '0;
        for (int i = 0; i < `AL_DISPATCH_WIDTH; i++) begin
            pushTag[i] = tail + activeListPkg::alIndex'(pushNum);
            if (dispatchValid[i]) begin
                pushNum = pushNum + 1'b1;
            end
        end
    end

    // Oldest entries while committing, youngest while walking back
    always_comb begin
        for (int i = 0; i < `AL_COMMIT_WIDTH; i++) begin
            if (state == activeListPkg::flushWalk) begin
                readTag[i] = tail - activeListPkg::alIndex'(i + 1);
            end else begin
                readTag[i] = head + activeListPkg::alIndex'(i);
            end
        end
    end

    always_comb begin
        faultAtHead = faultPending && (count != '0) && headDone[0] && (faultTag == head);
        commitChain = 1'b1;
        popNum = '0;
        faultValid = 1'b0;
        stateNext = state;
        for (int i = 0; i < `AL_COMMIT_WIDTH; i++) begin
            commitValid[i] = 1'b0;
            flushValid[i] = 1'b0;
        end

        if (state == activeListPkg::commitMode) begin
            if (faultAtHead) begin
                // Report alone, recovery starts next cycle
                faultValid = 1'b1;
                stateNext = activeListPkg::flushWalk;
            end else begin
                // In-order retirement, stops at the first lane that can't go
                for (int i = 0; i < `AL_COMMIT_WIDTH; i++) begin
                    commitChain = commitChain && (activeListPkg::alCount'(i) < count)
                        && headDone[i] && !(faultPending && (readTag[i] == faultTag));
                    commitValid[i] = commitChain;
                    if (commitChain) begin
                        popNum = popNum + 1'b1;
                    end
                end
            end
        end else begin
            for (int i = 0; i < `AL_COMMIT_WIDTH; i++) begin
                flushValid[i] = activeListPkg::alCount'(i) < count;
                if (flushValid[i]) begin
                    popNum = popNum + 1'b1;
                end
            end
            // Last entries leave this cycle
            if (count == activeListPkg::alCount'(popNum)) begin
                stateNext = activeListPkg::commitMode;
            end
        end
    end

    assign clearFault = faultValid;
    assign recovering = (state == activeListPkg::flushWalk);
    assign creditReturn = activeListPkg::alCount'(popNum);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= activeListPkg::commitMode;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            state <= stateNext;
            count <= count + activeListPkg::alCount'(pushNum)
                - activeListPkg::alCount'(popNum);
            if (state == activeListPkg::flushWalk) begin
                // Walk back, no dispatch during recovery
                tail <= tail - activeListPkg::alIndex'(popNum);
            end else begin
                head <= head + activeListPkg::alIndex'(popNum);
                tail <= tail + activeListPkg::alIndex'(pushNum);
            end
        end
    end

endmodule

`default_nettype wire

// File: design/activeListPkg.sv
// **************************************************
// Active list package
// Vector types for tags, counts and payload fields
// Recovery state machine encoding
// **************************************************

`default_nettype none

`include "activeList_consts.svh"

package activeListPkg;

    // Entry index, doubles as the instruction tag
    typedef logic [$clog2(`AL_ENTRY_NUM)-1:0] alIndex;

    // Occupancy and credit amounts span 0..AL_ENTRY_NUM
    typedef logic [$clog2(`AL_ENTRY_NUM):0] alCount;

    // Lanes active in one cycle
    typedef logic [$clog2(`AL_COMMIT_WIDTH):0] laneCount;

    // Payload fields
    typedef logic [`AL_PC_BITS-1:0] pcAddr;
    typedef logic [`AL_REG_BITS-1:0] archReg;
    typedef logic [`AL_CAUSE_BITS-1:0] faultCause;

    // Normal retirement vs. walking back from the tail
    typedef enum logic {
        commitMode,
        flushWalk
    } recoveryState;

endpackage

`default_nettype wire

// File: design/activeList_consts.svh
// **************************************************
// Active list constants
// Entry count, lane counts and payload field widths
// **************************************************

`ifndef ACTIVE_LIST_CONSTS_SVH
`define ACTIVE_LIST_CONSTS_SVH

// Queue depth
`define AL_ENTRY_NUM 16

// Lanes per cycle
`define AL_DISPATCH_WIDTH 2
`define AL_COMMIT_WIDTH 2
`define AL_WB_WIDTH 2

// Payload field widths
`define AL_PC_BITS 32
`define AL_REG_BITS 5
`define AL_CAUSE_BITS 4

`endif

// File: design/completionTable.sv
// **************************************************
// Completion table
// One done bit per entry, cleared at dispatch and
// set at writeback
// **************************************************

`default_nettype none

`include "activeList_consts.svh"

module completionTable (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pushValid [`AL_DISPATCH_WIDTH],
    input  activeListPkg::alIndex  pushTag [`AL_DISPATCH_WIDTH],
    input  logic                   wbValid [`AL_WB_WIDTH],
    input  activeListPkg::alIndex  wbTag [`AL_WB_WIDTH],
    input  activeListPkg::alIndex  readTag [`AL_COMMIT_WIDTH],
    output logic                   headDone [`AL_COMMIT_WIDTH]
);

    logic [`AL_ENTRY_NUM-1:0] doneBits;

    always_ff @(posedge clk) begin
        if (reset) begin
            doneBits <= '0;
        end else begin
            // Fresh entries start unfinished
            for (int i = 0; i < `AL_DISPATCH_WIDTH; i++) begin
                if (pushValid[i]) begin
                    doneBits[pushTag[i]] <= 1'b0;
                end
            end
            // Faulting results count as done too
            for (int i = 0; i < `AL_WB_WIDTH; i++) begin
                if (wbValid[i]) begin
                    doneBits[wbTag[i]] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `AL_COMMIT_WIDTH; i++) begin
            headDone[i] = doneBits[readTag[i]];
        end
    end

endmodule

`default_nettype wire

// File: design/entryStore.sv
// **************************************************
// Entry payload store
// PC and destination register per entry,
// written at dispatch, read at head/tail and wb tag
// **************************************************

`default_nettype none

`include "activeList_consts.svh"

module entryStore (
    input  logic                   clk,
    input  logic                   pushValid [`AL_DISPATCH_WIDTH],
    input  activeListPkg::alIndex  pushTag [`AL_DISPATCH_WIDTH],
    input  activeListPkg::pcAddr   pushPc [`AL_DISPATCH_WIDTH],
    input  activeListPkg::archReg  pushDest [`AL_DISPATCH_WIDTH],
    input  activeListPkg::alIndex  readTag [`AL_COMMIT_WIDTH],
    output activeListPkg::pcAddr   readPc [`AL_COMMIT_WIDTH],
    output activeListPkg::archReg  readDest [`AL_COMMIT_WIDTH],
    input  activeListPkg::alIndex  wbReadTag [`AL_WB_WIDTH],
    output activeListPkg::pcAddr   wbPc [`AL_WB_WIDTH]
);

    activeListPkg::pcAddr pcMem [`AL_ENTRY_NUM];
    activeListPkg::archReg destMem [`AL_ENTRY_NUM];

    // Dispatch lanes always target distinct slots
    always_ff @(posedge clk) begin
        for (int i = 0; i < `AL_DISPATCH_WIDTH; i++) begin
            if (pushValid[i]) begin
                pcMem[pushTag[i]] <= pushPc[i];
                destMem[pushTag[i]] <= pushDest[i];
            end
        end
    end

    // Asynchronous reads for commit and flush
    always_comb begin
        for (int i = 0; i < `AL_COMMIT_WIDTH; i++) begin
            readPc[i] = pcMem[readTag[i]];
            readDest[i] = destMem[readTag[i]];
        end
    end

    // PC of the writeback entry, for the fault record
    always_comb begin
        for (int i = 0; i < `AL_WB_WIDTH; i++) begin
            wbPc[i] = pcMem[wbReadTag[i]];
        end
    end

endmodule

`default_nettype wire

// File: design/faultTracker.sv
// **************************************************
// Fault tracker
// Keeps the oldest faulting entry, aged against head
// **************************************************

`default_nettype none

`include "activeList_consts.svh"

module faultTracker (
    input  logic                     clk,
    input  logic                     reset,
    input  activeListPkg::alIndex    head,
    input  logic                     wbValid [`AL_WB_WIDTH],
    input  activeListPkg::alIndex    wbTag [`AL_WB_WIDTH],
    input  logic                     wbFault [`AL_WB_WIDTH],
    input  activeListPkg::faultCause wbCause [`AL_WB_WIDTH],
    input  activeListPkg::pcAddr     wbPc [`AL_WB_WIDTH],
    input  logic                     clearFault,
    output logic                     faultPending,
    output activeListPkg::alIndex    faultTag,
    output activeListPkg::faultCause faultCause,
    output activeListPkg::pcAddr     faultPc
);

    logic recValid;
    activeListPkg::alIndex recTag;
    activeListPkg::faultCause recCause;
    activeListPkg::pcAddr recPc;

    logic nextValid;
    activeListPkg::alIndex nextTag;
    activeListPkg::faultCause nextCause;
    activeListPkg::pcAddr nextPc;

    // Distance from head, wraps mod entry count
    activeListPkg::alIndex oldestAge;
    activeListPkg::alIndex laneAge [`AL_WB_WIDTH];

    always_comb begin
        nextValid = recValid;
        nextTag = recTag;
        nextCause = recCause;
        nextPc = recPc;
        oldestAge = recTag - head;
        for (int i = 0; i < `AL_WB_WIDTH; i++) begin
            laneAge[i] = wbTag[i] - head;
            // Younger lanes also compete against an earlier lane's fault
            if (wbValid[i] && wbFault[i] && (!nextValid || laneAge[i] < oldestAge)) begin
                nextValid = 1'b1;
                nextTag = wbTag[i];
                nextCause = wbCause[i];
                nextPc = wbPc[i];
                oldestAge = laneAge[i];
            end
        end
    end

    // Recovery flushes everything younger, so new faults are dropped too
    always_ff @(posedge clk) begin
        if (reset || clearFault) begin
            recValid <= 1'b0;
        end else begin
            recValid <= nextValid;
        end
    end

    always_ff @(posedge clk) begin
        recTag <= nextTag;
        recCause <= nextCause;
        recPc <= nextPc;
    end

    assign faultPending = recValid;
    assign faultTag = recTag;
    assign faultCause = recCause;
    assign faultPc = recPc;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Builds the active list testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module activeListTb -f sim.f \
    && ./obj_dir/VactiveListTb | tee sim.log \
    && grep -q "^Everything OK$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: sim.f
+incdir+design
design/activeListPkg.sv
design/activeListControl.sv
design/entryStore.sv
design/completionTable.sv
design/faultTracker.sv
design/activeList.sv
tb/activeListTb.sv

// File: tb/activeListTb.sv
// **************************************************
// Active list testbench
// Xorshift dispatch and writeback stimulus, queue
// model of live entries, output checks, watchdog
// **************************************************

`default_nettype none

`include "activeList_consts.svh"

module activeListTb;

    localparam int TEST_CYCLES = 3000;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        activeListPkg::alIndex tag;
        activeListPkg::pcAddr pc;
        activeListPkg::archReg dest;
        logic done;
        logic fault;
        activeListPkg::faultCause cause;
    } modelEntry;

    logic clk = 1'b0;
    logic reset;
    logic dispatchValid [`AL_DISPATCH_WIDTH];
    activeListPkg::pcAddr dispatchPc [`AL_DISPATCH_WIDTH];
    activeListPkg::archReg dispatchDest [`AL_DISPATCH_WIDTH];
    activeListPkg::alIndex dispatchTag [`AL_DISPATCH_WIDTH];
    logic wbValid [`AL_WB_WIDTH];
    activeListPkg::alIndex wbTag [`AL_WB_WIDTH];
    logic wbFault [`AL_WB_WIDTH];
    activeListPkg::faultCause wbCause [`AL_WB_WIDTH];
    logic commitValid [`AL_COMMIT_WIDTH];
    activeListPkg::pcAddr commitPc [`AL_COMMIT_WIDTH];
    activeListPkg::archReg commitDest [`AL_COMMIT_WIDTH];
    logic flushValid [`AL_COMMIT_WIDTH];
    activeListPkg::pcAddr flushPc [`AL_COMMIT_WIDTH];
    activeListPkg::archReg flushDest [`AL_COMMIT_WIDTH];
    logic faultValid;
    activeListPkg::pcAddr faultPc;
    activeListPkg::faultCause faultCause;
    activeListPkg::alCount creditReturn;
    logic recovering;

    // Reference model, oldest entry at index 0
    modelEntry model [$];
    int credits;
    activeListPkg::alIndex modelTail;
    logic modelRecovering;
    logic [31:0] rng;
    int faultsSeen;
    int commitsSeen;

    activeList dut (
        .clk(clk), .reset(reset), .dispatchValid(dispatchValid), .dispatchPc(dispatchPc),
        .dispatchDest(dispatchDest), .dispatchTag(dispatchTag), .wbValid(wbValid),
        .wbTag(wbTag), .wbFault(wbFault), .wbCause(wbCause), .commitValid(commitValid),
        .commitPc(commitPc), .commitDest(commitDest), .flushValid(flushValid),
        .flushPc(flushPc), .flushDest(flushDest), .faultValid(faultValid),
        .faultPc(faultPc), .faultCause(faultCause), .creditReturn(creditReturn),
        .recovering(recovering)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stopOnError(input string msg);
        $display("error at time %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    // Runs right after a rising edge, model already holds the post-edge state
    task automatic driveStimulus();
        int numDisp;
        int pick;
        int candidates [$];
        rng = xorshift(rng);
        numDisp = modelRecovering ? 0 : int'(rng % 3);
        if (numDisp > credits) begin
            numDisp = credits;
        end
        for (int i = 0; i < `AL_DISPATCH_WIDTH; i++) begin
            rng = xorshift(rng);
            dispatchValid[i] <= (i < numDisp);
            dispatchPc[i] <= rng;
            dispatchDest[i] <= activeListPkg::archReg'(rng >> 7);
        end
        // Live entries still waiting for a result
        for (int k = 0; k < model.size(); k++) begin
            if (!model[k].done) begin
                candidates.push_back(k);
            end
        end
        for (int i = 0; i < `AL_WB_WIDTH; i++) begin
            rng = xorshift(rng);
            if (!modelRecovering && candidates.size() > 0 && rng[0]) begin
                pick = int'(rng[12:8]) % candidates.size();
                wbValid[i] <= 1'b1;
                wbTag[i] <= model[candidates[pick]].tag;
                wbFault[i] <= (rng[23:20] == 4'd0);
                wbCause[i] <= activeListPkg::faultCause'(rng >> 24);
                candidates.delete(pick);
            end else begin
                wbValid[i] <= 1'b0;
                wbTag[i] <= '0;
                wbFault[i] <= 1'b0;
                wbCause[i] <= '0;
            end
        end
    endtask

    task automatic checkAndUpdate();
        int expCommit;
        int expFlush;
        logic expFault;
        int last;
        modelEntry e;
        expCommit = 0;
        expFlush = 0;
        expFault = 1'b0;
        for (int i = 0; i < `AL_DISPATCH_WIDTH; i++) begin
            assert (!dispatchValid[i] || dispatchTag[i] == modelTail + activeListPkg::alIndex'(i))
            else stopOnError($sformatf("dispatchTag[%0d] is %0d, expected %0d", i,
                dispatchTag[i], modelTail + activeListPkg::alIndex'(i)));
        end
        if (modelRecovering) begin
            expFlush = (model.size() < 2) ? model.size() : 2;
        end else if (model.size() > 0 && model[0].done && model[0].fault) begin
            expFault = 1'b1;
        end else begin
            while (expCommit < 2 && expCommit < model.size() && model[expCommit].done
                    && !model[expCommit].fault) begin
                expCommit++;
            end
        end
        assert (faultValid == expFault && recovering == modelRecovering)
        else stopOnError($sformatf("faultValid %0b recovering %0b, expected %0b %0b",
            faultValid, recovering, expFault, modelRecovering));
        assert (!expFault || (faultPc == model[0].pc && faultCause == model[0].cause))
        else stopOnError($sformatf("fault report pc %h cause %0d, expected %h %0d",
            faultPc, faultCause, model[0].pc, model[0].cause));
        for (int i = 0; i < `AL_COMMIT_WIDTH; i++) begin
            last = model.size() - 1 - i;
            assert (commitValid[i] == (i < expCommit) && flushValid[i] == (i < expFlush))
            else stopOnError($sformatf("lane %0d commit %0b flush %0b, expected %0b %0b", i,
                commitValid[i], flushValid[i], i < expCommit, i < expFlush));
            assert (i >= expCommit
                    || (commitPc[i] == model[i].pc && commitDest[i] == model[i].dest))
            else stopOnError($sformatf("commit lane %0d pc %h dest %0d, expected %h %0d", i,
                commitPc[i], commitDest[i], model[i].pc, model[i].dest));
            assert (i >= expFlush
                    || (flushPc[i] == model[last].pc && flushDest[i] == model[last].dest))
            else stopOnError($sformatf("flush lane %0d pc %h dest %0d, expected %h %0d", i,
                flushPc[i], flushDest[i], model[last].pc, model[last].dest));
        end
        assert (int'(creditReturn) == expCommit + expFlush)
        else stopOnError($sformatf("creditReturn %0d, expected %0d", creditReturn,
            expCommit + expFlush));

        // Pops happen at the coming edge
        for (int i = 0; i < expCommit; i++) begin
            model.delete(0);
        end
        for (int i = 0; i < expFlush; i++) begin
            model.delete(model.size() - 1);
        end
        // Dispatcher takes back what the DUT returns
        credits += int'(creditReturn);
        modelTail = modelTail - activeListPkg::alIndex'(expFlush);
        commitsSeen += expCommit;
        if (expFault) begin
            modelRecovering = 1'b1;
            faultsSeen++;
        end else if (modelRecovering && model.size() == 0) begin
            modelRecovering = 1'b0;
        end
        for (int i = 0; i < `AL_WB_WIDTH; i++) begin
            for (int k = 0; k < model.size(); k++) begin
                if (wbValid[i] && model[k].tag == wbTag[i]) begin
                    e = model[k];
                    e.done = 1'b1;
                    e.fault = wbFault[i];
                    e.cause = wbCause[i];
                    model[k] = e;
                end
            end
        end
        for (int i = 0; i < `AL_DISPATCH_WIDTH; i++) begin
            if (dispatchValid[i]) begin
                e = '{tag: modelTail, pc: dispatchPc[i], dest: dispatchDest[i],
                    done: 1'b0, fault: 1'b0, cause: '0};
                model.push_back(e);
                modelTail = modelTail + activeListPkg::alIndex'(1);
                credits--;
            end
        end
        assert (credits >= 0 && (model.size() != 0 || credits == `AL_ENTRY_NUM))
        else stopOnError($sformatf("credit count %0d with %0d live entries", credits,
            model.size()));
    endtask

    initial begin
        reset = 1'b1;
        for (int i = 0; i < `AL_DISPATCH_WIDTH; i++) begin
            dispatchValid[i] = 1'b0;
            dispatchPc[i] = '0;
            dispatchDest[i] = '0;
        end
        for (int i = 0; i < `AL_WB_WIDTH; i++) begin
            wbValid[i] = 1'b0;
            wbTag[i] = '0;
            wbFault[i] = 1'b0;
            wbCause[i] = '0;
        end
        credits = `AL_ENTRY_NUM;
        modelTail = '0;
        modelRecovering = 1'b0;
        rng = 32'hbcdcfaed;
        faultsSeen = 0;
        commitsSeen = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int cycle = 0; cycle < TEST_CYCLES; cycle++) begin
            @(posedge clk);
            driveStimulus();
            // Outputs are settled by the falling edge
            @(negedge clk);
            checkAndUpdate();
        end
        if (faultsSeen > 0 && commitsSeen > 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stopOnError("the run saw no commit or no fault recovery");
        end
    end

    // Test length plus reset and some slack
    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + RESET_CYCLES + 100));
        stopOnError("watchdog timeout, the test loop did not reach its end");
    end

endmodule

`default_nettype wire
